/* project.f */
src/core_pkg.sv
src/pipeline_reg.sv
src/fetch_unit.sv
src/decoder.sv
src/regfile.sv
src/execute_unit.sv
src/retire_unit.sv
src/mini_core.sv
sim/tb_mini_core.sv

/* sim/tb_mini_core.sv */
module tb_mini_core;
  timeunit 1ns;
  timeprecision 1ps;

  localparam core_pkg::word_t LOOP_PC   = 32'd252;
  localparam core_pkg::word_t LOOP_INSN = 32'h0000_0063;

  logic              clk_i;
  logic              rst_i;
  core_pkg::word_t   imem_addr_o;
  core_pkg::word_t   imem_rdata_i;
  logic              retire_valid_o;
  core_pkg::retire_t retire_o;

  core_pkg::word_t prog [64];
  core_pkg::word_t m_regs [32];
  core_pkg::word_t m_pc;
  logic [31:0]     m_order;
  logic [31:0]     lcg_state;
  int              value_errors;
  int              other_errors;

  mini_core i_mini_core (
    .clk_i(clk_i), .rst_i(rst_i),
    .imem_addr_o(imem_addr_o), .imem_rdata_i(imem_rdata_i),
    .retire_valid_o(retire_valid_o), .retire_o(retire_o)
  );

  // addresses past the program read the halt loop
  assign imem_rdata_i = (imem_addr_o < 32'd256) ? prog[imem_addr_o[7:2]] : LOOP_INSN;

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return {16'd0, lcg_state[31:16]};
  endfunction

  function automatic core_pkg::word_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
      input core_pkg::reg_addr_t rd, input core_pkg::reg_addr_t rs1,
      input core_pkg::reg_addr_t rs2);
    return {f7, rs2, rs1, f3, rd, core_pkg::OPC_OP};
  endfunction

  function automatic core_pkg::word_t enc_i(input logic [2:0] f3, input core_pkg::reg_addr_t rd,
      input core_pkg::reg_addr_t rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, core_pkg::OPC_OP_IMM};
  endfunction

  function automatic core_pkg::word_t enc_b(input logic [2:0] f3, input core_pkg::reg_addr_t rs1,
      input core_pkg::reg_addr_t rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], core_pkg::OPC_BRANCH};
  endfunction

  task automatic build_program();
    logic [31:0]         kind;
    logic [31:0]         r;
    logic [6:0]          f7;
    logic [2:0]          f3;
    core_pkg::reg_addr_t rd;
    core_pkg::reg_addr_t rs1;
    core_pkg::reg_addr_t rs2;
    logic [11:0]         imm;
    for (int i = 0; i < 63; i++) begin
      kind = next_random() % 10;
      rd   = next_random() % 8;
      rs1  = next_random() % 8;
      rs2  = next_random() % 8;
      imm  = next_random() % 64;
      imm  = imm - 12'd32;
      r    = next_random();
      f7   = 7'b0000000;
      if (kind < 4) begin
        case (r % 6)
          0: f3 = 3'b000;
          1: begin
            f3 = 3'b000;
            f7 = 7'b0100000;
          end
          2: f3 = 3'b111;
          3: f3 = 3'b110;
          4: f3 = 3'b100;
          default: f3 = 3'b010;
        endcase
        prog[i] = enc_r(f7, f3, rd, rs1, rs2);
      end else if (kind < 6) begin
        case (r % 4)
          0: f3 = 3'b000;
          1: f3 = 3'b111;
          2: f3 = 3'b110;
          default: f3 = 3'b100;
        endcase
        prog[i] = enc_i(f3, rd, rs1, imm);
      end else if (kind == 6) begin
        prog[i] = {4'h0, r[15:0], rd, core_pkg::OPC_LUI};
      end else if (kind < 9 && i < 60) begin
        // forward only, +8 or +12, BEQ or BNE
        prog[i] = enc_b({2'b00, r[0]}, rs1, rs2, r[1] ? 13'd12 : 13'd8);
      end else if (kind == 9) begin
        prog[i] = {r[14:0], 5'd0, rd, 7'b0001011};
      end else begin
        prog[i] = enc_i(3'b000, rd, rs1, imm);
      end
    end
    prog[63] = LOOP_INSN;
  endtask

  //////////////////////////////////////////////////////////////////////
  // reference model and checks
  //////////////////////////////////////////////////////////////////////

  task automatic model_step(output core_pkg::retire_t exp_r);
    core_pkg::word_t     insn;
    core_pkg::word_t     a;
    core_pkg::word_t     b;
    core_pkg::word_t     imm_i;
    core_pkg::word_t     imm_b;
    core_pkg::word_t     res;
    core_pkg::word_t     next_pc_v;
    core_pkg::reg_addr_t rd;
    insn      = (m_pc < 32'd256) ? prog[m_pc[7:2]] : LOOP_INSN;
    a         = m_regs[insn[19:15]];
    b         = m_regs[insn[24:20]];
    imm_i     = {{20{insn[31]}}, insn[31:20]};
    imm_b     = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
    rd        = insn[11:7];
    res       = '0;
    next_pc_v = m_pc + 32'd4;
    case (insn[6:0])
      core_pkg::OPC_OP: begin
        case ({insn[31:25], insn[14:12]})
          {7'h00, 3'b000}: res = a + b;
          {7'h20, 3'b000}: res = a - b;
          {7'h00, 3'b111}: res = a & b;
          {7'h00, 3'b110}: res = a | b;
          {7'h00, 3'b100}: res = a ^ b;
          {7'h00, 3'b010}: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          default: rd = '0;
        endcase
      end
      core_pkg::OPC_OP_IMM: begin
        case (insn[14:12])
          3'b000: res = a + imm_i;
          3'b111: res = a & imm_i;
          3'b110: res = a | imm_i;
          3'b100: res = a ^ imm_i;
          default: rd = '0;
        endcase
      end
      core_pkg::OPC_LUI: res = {insn[31:12], 12'h000};
      core_pkg::OPC_BRANCH: begin
        rd = '0;
        if ((insn[14:12] == 3'b000 && a == b) || (insn[14:12] == 3'b001 && a != b)) begin
          next_pc_v = m_pc + imm_b;
        end
      end
      default: rd = '0;
    endcase
    if (rd == '0) begin
      res = '0;
    end else begin
      m_regs[rd] = res;
    end
    exp_r.order    = m_order;
    exp_r.pc       = m_pc;
    exp_r.next_pc  = next_pc_v;
    exp_r.insn     = insn;
    exp_r.rd_addr  = rd;
    exp_r.rd_wdata = res;
    m_order = m_order + 32'd1;
    m_pc    = next_pc_v;
  endtask

  task automatic check_word(input string name, input core_pkg::word_t exp_w,
      input core_pkg::word_t act_w);
    if (act_w !== exp_w) begin
      value_errors++;
      $display("Fail %s: expected %h actual %h", name, exp_w, act_w);
    end
  endtask

  task automatic check_retire(input string name, input core_pkg::retire_t exp_r,
      input core_pkg::retire_t act_r);
    check_word({name, " order"}, exp_r.order, act_r.order);
    check_word({name, " pc"}, exp_r.pc, act_r.pc);
    check_word({name, " next_pc"}, exp_r.next_pc, act_r.next_pc);
    check_word({name, " insn"}, exp_r.insn, act_r.insn);
    check_word({name, " rd_wdata"}, exp_r.rd_wdata, act_r.rd_wdata);
    if (act_r.rd_addr !== exp_r.rd_addr) begin
      value_errors++;
      $display("Fail %s rd: expected %0d actual %0d", name, exp_r.rd_addr, act_r.rd_addr);
    end
  endtask

  task automatic wait_retire(output logic got);
    got = 1'b0;
    for (int n = 0; n < 20; n++) begin
      @(negedge clk_i);
      if (retire_valid_o === 1'b1) begin
        got = 1'b1;
        break;
      end
    end
  endtask

  initial begin
    core_pkg::retire_t exp_r;
    logic              got;
    int                loop_hits;
    int                count;
    lcg_state    = 32'd3;
    value_errors = 0;
    other_errors = 0;
    loop_hits    = 0;
    count        = 0;
    rst_i        = 1'b1;
    for (int i = 0; i < 32; i++) begin
      m_regs[i] = '0;
    end
    m_pc    = core_pkg::RESET_PC;
    m_order = '0;
    build_program();

    // five reset edges, then three cycles of pipeline fill
    @(posedge clk_i);
    for (int i = 0; i < 7; i++) begin
      @(negedge clk_i);
      if (retire_valid_o !== 1'b0) begin
        other_errors++;
        $display("retirement strobe seen during reset or pipeline fill");
      end
      if (i < 4) begin
        check_word("reset imem_addr", core_pkg::RESET_PC, imem_addr_o);
      end
      @(posedge clk_i);
      if (i == 3) begin
        rst_i <= 1'b0;
      end
    end

    got = 1'b1;
    while (loop_hits < 3 && got) begin
      model_step(exp_r);
      wait_retire(got);
      if (!got) begin
        other_errors++;
        $display("timeout: no retirement arrived within 20 cycles");
      end else begin
        check_retire($sformatf("retire %0d", count), exp_r, retire_o);
        count++;
        if (exp_r.pc == LOOP_PC) begin
          loop_hits++;
        end
      end
    end

    $display("errors: %0d value, %0d other", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* src/core_pkg.sv */
package core_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths and reset values
  //////////////////////////////////////////////////////////////////////

  localparam int XLEN     = 32;
  localparam int NUM_REGS = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [$clog2(NUM_REGS)-1:0] reg_addr_t;

  localparam word_t RESET_PC = '0;

  // major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  // funct3 encodings
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [2:0] F3_BNE     = 3'b001;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [1:0] {
    BR_NONE,
    BR_BEQ,
    BR_BNE
  } branch_e;

  //////////////////////////////////////////////////////////////////////
  // stage packets
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic  valid;
    word_t pc;
    word_t insn;
  } if_id_t;

  typedef struct packed {
    logic      valid;
    word_t     pc;
    word_t     insn;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     imm;
    logic      use_imm;
    alu_op_e   alu_op;
    branch_e   branch;
    reg_addr_t rd_addr;
  } id_ex_t;

  typedef struct packed {
    logic      valid;
    word_t     pc;
    word_t     next_pc;
    word_t     insn;
    reg_addr_t rd_addr;
    word_t     result;
  } ex_wb_t;

  // retirement trace
  typedef struct packed {
    logic [31:0] order;
    word_t       pc;
    word_t       next_pc;
    word_t       insn;
    reg_addr_t   rd_addr;
    word_t       rd_wdata;
  } retire_t;

endpackage

/* src/decoder.sv */
module decoder (
  input  core_pkg::if_id_t    fetch_i,
  output core_pkg::reg_addr_t rs1_addr_o,
  output core_pkg::reg_addr_t rs2_addr_o,
  input  core_pkg::word_t     rs1_data_i,
  input  core_pkg::word_t     rs2_data_i,
  output core_pkg::id_ex_t    decode_o
);

  core_pkg::word_t insn;
  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  core_pkg::word_t imm_i;
  core_pkg::word_t imm_b;
  core_pkg::word_t imm_u;

  assign insn   = fetch_i.insn;
  assign opcode = insn[6:0];
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];

  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  assign rs1_addr_o = insn[19:15];
  assign rs2_addr_o = insn[24:20];

  always_comb begin
    decode_o.valid    = fetch_i.valid;
    decode_o.pc       = fetch_i.pc;
    decode_o.insn     = insn;
    decode_o.rs1_addr = rs1_addr_o;
    decode_o.rs2_addr = rs2_addr_o;
    decode_o.rs1_data = rs1_data_i;
    decode_o.rs2_data = rs2_data_i;
    decode_o.imm      = imm_i;
    decode_o.use_imm  = 1'b0;
    decode_o.alu_op   = core_pkg::ALU_ADD;
    decode_o.branch   = core_pkg::BR_NONE;
    decode_o.rd_addr  = insn[11:7];
    // anything not matched below drops to an add into x0
    case (opcode)
      core_pkg::OPC_OP: begin
        if (funct7 == 7'b0100000 && funct3 == core_pkg::F3_ADD_SUB) begin
          decode_o.alu_op = core_pkg::ALU_SUB;
        end else if (funct7 != 7'b0000000) begin
          decode_o.rd_addr = '0;
        end else begin
          case (funct3)
            core_pkg::F3_ADD_SUB: decode_o.alu_op = core_pkg::ALU_ADD;
            core_pkg::F3_SLT:     decode_o.alu_op = core_pkg::ALU_SLT;
            core_pkg::F3_XOR:     decode_o.alu_op = core_pkg::ALU_XOR;
            core_pkg::F3_OR:      decode_o.alu_op = core_pkg::ALU_OR;
            core_pkg::F3_AND:     decode_o.alu_op = core_pkg::ALU_AND;
            default:              decode_o.rd_addr = '0;
          endcase
        end
      end
      core_pkg::OPC_OP_IMM: begin
        decode_o.use_imm = 1'b1;
        case (funct3)
          core_pkg::F3_ADD_SUB: decode_o.alu_op = core_pkg::ALU_ADD;
          core_pkg::F3_XOR:     decode_o.alu_op = core_pkg::ALU_XOR;
          core_pkg::F3_OR:      decode_o.alu_op = core_pkg::ALU_OR;
          core_pkg::F3_AND:     decode_o.alu_op = core_pkg::ALU_AND;
          default:              decode_o.rd_addr = '0;
        endcase
      end
      core_pkg::OPC_LUI: begin
        decode_o.use_imm = 1'b1;
        decode_o.imm     = imm_u;
        decode_o.alu_op  = core_pkg::ALU_PASS_B;
      end
      core_pkg::OPC_BRANCH: begin
        decode_o.imm     = imm_b;
        decode_o.rd_addr = '0;
        if (funct3 == core_pkg::F3_BEQ) begin
          decode_o.branch = core_pkg::BR_BEQ;
        end else if (funct3 == core_pkg::F3_BNE) begin
          decode_o.branch = core_pkg::BR_BNE;
        end
      end
      default: decode_o.rd_addr = '0;
    endcase
  end

endmodule

/* src/execute_unit.sv */
module execute_unit (
  input  core_pkg::id_ex_t decode_i,
  input  core_pkg::ex_wb_t wb_i,
  output core_pkg::ex_wb_t exec_o,
  output logic             redirect_o,
  output core_pkg::word_t  redirect_pc_o
);

  //////////////////////////////////////////////////////////////////////
  // forwarding from writeback
  //////////////////////////////////////////////////////////////////////

  core_pkg::word_t rs1_val;
  core_pkg::word_t rs2_val;
  core_pkg::word_t op_b;
  core_pkg::word_t alu_out;
  logic            equal;
  logic            taken;

  assign rs1_val = (wb_i.valid && wb_i.rd_addr != '0 && wb_i.rd_addr == decode_i.rs1_addr) ?
                   wb_i.result : decode_i.rs1_data;
  assign rs2_val = (wb_i.valid && wb_i.rd_addr != '0 && wb_i.rd_addr == decode_i.rs2_addr) ?
                   wb_i.result : decode_i.rs2_data;

  assign op_b = decode_i.use_imm ? decode_i.imm : rs2_val;

  always_comb begin
    case (decode_i.alu_op)
      core_pkg::ALU_SUB:    alu_out = rs1_val - op_b;
      core_pkg::ALU_AND:    alu_out = rs1_val & op_b;
      core_pkg::ALU_OR:     alu_out = rs1_val | op_b;
      core_pkg::ALU_XOR:    alu_out = rs1_val ^ op_b;
      core_pkg::ALU_SLT:    alu_out = {{(core_pkg::XLEN-1){1'b0}}, $signed(rs1_val) < $signed(op_b)};
      core_pkg::ALU_PASS_B: alu_out = op_b;
      default:              alu_out = rs1_val + op_b;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // branch resolution
  //////////////////////////////////////////////////////////////////////

  assign equal = (rs1_val == rs2_val);
  assign taken = decode_i.valid &&
                 ((decode_i.branch == core_pkg::BR_BEQ && equal) ||
                  (decode_i.branch == core_pkg::BR_BNE && !equal));

  // also flushes fetch/decode and decode/execute
  assign redirect_o    = taken;
  assign redirect_pc_o = decode_i.pc + decode_i.imm;

  assign exec_o.valid   = decode_i.valid;
  assign exec_o.pc      = decode_i.pc;
  assign exec_o.next_pc = taken ? redirect_pc_o : decode_i.pc + 32'd4;
  assign exec_o.insn    = decode_i.insn;
  assign exec_o.rd_addr = decode_i.rd_addr;
  assign exec_o.result  = alu_out;

endmodule

/* src/fetch_unit.sv */
module fetch_unit (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             redirect_i,
  input  core_pkg::word_t  redirect_pc_i,
  input  core_pkg::word_t  imem_rdata_i,
  output core_pkg::word_t  imem_addr_o,
  output core_pkg::if_id_t fetch_o
);

  core_pkg::word_t pc_q;

  // branch target wins over the sequential advance
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pc_q <= core_pkg::RESET_PC;
    end else if (redirect_i) begin
      pc_q <= redirect_pc_i;
    end else begin
      pc_q <= pc_q + 32'd4;
    end
  end

  assign imem_addr_o = pc_q;

  // imem answers in the same cycle
  assign fetch_o.valid = 1'b1;
  assign fetch_o.pc    = pc_q;
  assign fetch_o.insn  = imem_rdata_i;

endmodule

/* src/mini_core.sv */
module mini_core (
  input  logic              clk_i,
  input  logic              rst_i,
  output core_pkg::word_t   imem_addr_o,
  input  core_pkg::word_t   imem_rdata_i,
  output logic              retire_valid_o,
  output core_pkg::retire_t retire_o
);

  core_pkg::if_id_t    fetch_d;
  core_pkg::if_id_t    fetch_q;
  core_pkg::id_ex_t    decode_d;
  core_pkg::id_ex_t    decode_q;
  core_pkg::ex_wb_t    exec_d;
  core_pkg::ex_wb_t    wb_q;
  logic                redirect;
  core_pkg::word_t     redirect_pc;
  core_pkg::reg_addr_t rs1_addr;
  core_pkg::reg_addr_t rs2_addr;
  core_pkg::word_t     rs1_data;
  core_pkg::word_t     rs2_data;
  logic                rd_wen;
  core_pkg::reg_addr_t rd_addr;
  core_pkg::word_t     rd_data;

  fetch_unit i_fetch_unit (
    .clk_i(clk_i), .rst_i(rst_i),
    .redirect_i(redirect), .redirect_pc_i(redirect_pc),
    .imem_rdata_i(imem_rdata_i), .imem_addr_o(imem_addr_o),
    .fetch_o(fetch_d)
  );

  pipeline_reg #(.pipe_t(core_pkg::if_id_t)) i_if_id_reg (
    .clk_i(clk_i), .rst_i(rst_i), .flush_i(redirect),
    .pipe_d_i(fetch_d), .pipe_q_o(fetch_q)
  );

  decoder i_decoder (
    .fetch_i(fetch_q), .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
    .rs1_data_i(rs1_data), .rs2_data_i(rs2_data), .decode_o(decode_d)
  );

  regfile i_regfile (
    .clk_i(clk_i), .rst_i(rst_i),
    .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
    .rd_addr_i(rd_addr), .rd_wen_i(rd_wen), .rd_data_i(rd_data),
    .rs1_data_o(rs1_data), .rs2_data_o(rs2_data)
  );

  pipeline_reg #(.pipe_t(core_pkg::id_ex_t)) i_id_ex_reg (
    .clk_i(clk_i), .rst_i(rst_i), .flush_i(redirect),
    .pipe_d_i(decode_d), .pipe_q_o(decode_q)
  );

  execute_unit i_execute_unit (
    .decode_i(decode_q), .wb_i(wb_q), .exec_o(exec_d),
    .redirect_o(redirect), .redirect_pc_o(redirect_pc)
  );

  // the oldest instruction is never flushed
  pipeline_reg #(.pipe_t(core_pkg::ex_wb_t)) i_ex_wb_reg (
    .clk_i(clk_i), .rst_i(rst_i), .flush_i(1'b0),
    .pipe_d_i(exec_d), .pipe_q_o(wb_q)
  );

  retire_unit i_retire_unit (
    .clk_i(clk_i), .rst_i(rst_i), .wb_i(wb_q),
    .rd_wen_o(rd_wen), .rd_addr_o(rd_addr), .rd_data_o(rd_data),
    .retire_valid_o(retire_valid_o), .retire_o(retire_o)
  );

endmodule

/* src/pipeline_reg.sv */
module pipeline_reg #(
  parameter type pipe_t = struct packed {
    logic        valid;
    logic [31:0] data;
  }
) (
  input  logic  clk_i,
  input  logic  rst_i,
  input  logic  flush_i,
  input  pipe_t pipe_d_i,
  output pipe_t pipe_q_o
);

  // payload moves every cycle, only valid is cleared
  always_ff @(posedge clk_i) begin
    pipe_q_o <= pipe_d_i;
    if (rst_i || flush_i) begin
      pipe_q_o.valid <= 1'b0;
    end
  end

  valid_known_a : assert property (
    @(posedge clk_i) disable iff (rst_i)
    !$isunknown(pipe_q_o.valid)
  );

endmodule

/* src/regfile.sv */
module regfile (
  input  logic                clk_i,
  input  logic                rst_i,
  input  core_pkg::reg_addr_t rs1_addr_i,
  input  core_pkg::reg_addr_t rs2_addr_i,
  input  core_pkg::reg_addr_t rd_addr_i,
  input  logic                rd_wen_i,
  input  core_pkg::word_t     rd_data_i,
  output core_pkg::word_t     rs1_data_o,
  output core_pkg::word_t     rs2_data_o
);

  core_pkg::word_t regs [core_pkg::NUM_REGS];
  logic            wen;

  // x0 is never written, so it keeps its reset value
  assign wen = rd_wen_i && (rd_addr_i != '0);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < core_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen) begin
      regs[rd_addr_i] <= rd_data_i;
    end
  end

  // write-through for the instruction two behind the writer
  assign rs1_data_o = (wen && rd_addr_i == rs1_addr_i) ? rd_data_i : regs[rs1_addr_i];
  assign rs2_data_o = (wen && rd_addr_i == rs2_addr_i) ? rd_data_i : regs[rs2_addr_i];

  x0_zero_a : assert property (
    @(posedge clk_i) disable iff (rst_i)
    (rs1_addr_i != '0 || rs1_data_o == '0) && (rs2_addr_i != '0 || rs2_data_o == '0)
  );

endmodule

/* src/retire_unit.sv */
module retire_unit (
  input  logic                clk_i,
  input  logic                rst_i,
  input  core_pkg::ex_wb_t    wb_i,
  output logic                rd_wen_o,
  output core_pkg::reg_addr_t rd_addr_o,
  output core_pkg::word_t     rd_data_o,
  output logic                retire_valid_o,
  output core_pkg::retire_t   retire_o
);

  logic [31:0] order_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      order_q <= '0;
    end else if (wb_i.valid) begin
      order_q <= order_q + 32'd1;
    end
  end

  assign rd_wen_o  = wb_i.valid;
  assign rd_addr_o = wb_i.rd_addr;
  assign rd_data_o = wb_i.result;

  assign retire_valid_o    = wb_i.valid;
  assign retire_o.order    = order_q;
  assign retire_o.pc       = wb_i.pc;
  assign retire_o.next_pc  = wb_i.next_pc;
  assign retire_o.insn     = wb_i.insn;
  assign retire_o.rd_addr  = wb_i.rd_addr;
  // trace shows zero for anything aimed at x0
  assign retire_o.rd_wdata = (wb_i.rd_addr == '0) ? '0 : wb_i.result;

  order_step_a : assert property (
    @(posedge clk_i) disable iff (rst_i)
    retire_valid_o |=> (retire_o.order == $past(retire_o.order) + 32'd1)
  );

endmodule
